// ==== hdl/rename_defs.svh ====
// Rename stage sizing
// Register counts and checkpoint depth for the rename hardware

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Integer registers visible to software
`define RN_NUM_ARCH_REGS 32

// Physical register file size
`define RN_NUM_PHYS_REGS 64

// Branch snapshots in flight
`define RN_NUM_CKPTS 4

// Free list holds every physical register not mapped at reset
// Must stay a power of two so the pointers wrap on their own
`define RN_FREE_DEPTH (`RN_NUM_PHYS_REGS - `RN_NUM_ARCH_REGS)

`endif

// ==== hdl/isa_pkg.sv ====
// RISC-V instruction formats
// Opcode classes seen by rename and the two views of a 32-bit word

package isa_pkg;

    // Major opcodes that the rename stage tells apart
    typedef enum logic [6:0] {
        OP     = 7'b0110011,    // Register-register ALU
        OP_IMM = 7'b0010011,    // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcode_e;

    // R view used for OP, STORE and BRANCH sources
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    // I view where bits 31:20 hold an immediate
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    // One instruction word read either way
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

// ==== hdl/rename_pkg.sv ====
// Rename stage types
// Index types for architectural and physical registers and checkpoint labels

`include "rename_defs.svh"

package rename_pkg;

    // Architectural register index
    typedef logic [$clog2(`RN_NUM_ARCH_REGS)-1:0] areg_t;

    // Physical register index
    typedef logic [$clog2(`RN_NUM_PHYS_REGS)-1:0] preg_t;

    // Checkpoint label
    typedef logic [$clog2(`RN_NUM_CKPTS)-1:0] ckpt_t;

    // Full map table indexed by architectural register
    typedef preg_t map_t [`RN_NUM_ARCH_REGS];

endpackage

// ==== hdl/rename_decode.sv ====
// Rename decode
// Pulls register fields out of the instruction word and decides whether
// the stage can accept it this cycle

`timescale 1ns/10ps

module rename_decode (
    input  logic             instr_valid_i,
    input  isa_pkg::instr_u  instr_i,
    input  logic             recover_i,
    input  logic             fl_empty_i,     // No free physical register
    input  logic             ckpt_full_i,    // All snapshots in use
    output rename_pkg::areg_t rs1_o,
    output rename_pkg::areg_t rs2_o,
    output rename_pkg::areg_t rd_o,
    output logic             has_dest_o,
    output logic             rename_en_o,
    output logic             alloc_o,
    output logic             take_ckpt_o,
    output logic             stall_o
);
    logic use_rs1;
    logic use_rs2;
    logic writes_rd;
    logic is_branch;

    // Opcode class decode
    always_comb begin
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        case (instr_i.r.opcode)
            isa_pkg::OP: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
            end
            isa_pkg::OP_IMM, isa_pkg::LOAD: begin
                use_rs1   = 1'b1;       // Upper bits are imm12 here
                writes_rd = 1'b1;
            end
            isa_pkg::STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;         // Store data register
            end
            isa_pkg::BRANCH: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                is_branch = 1'b1;
            end
            isa_pkg::LUI, isa_pkg::JAL: writes_rd = 1'b1;
            default: ;                  // Unknown opcodes pass with no registers
        endcase
    end

    // Unused sources read as x0
    // rs1 sits in the same bits in both layouts
    assign rs1_o = use_rs1 ? instr_i.r.rs1 : '0;
    assign rs2_o = use_rs2 ? instr_i.r.rs2 : '0;

    // Writes to x0 are dropped and never allocate
    assign has_dest_o = writes_rd && (instr_i.r.rd != '0);
    assign rd_o       = has_dest_o ? instr_i.r.rd : '0;

    // Recover wins over any instruction in the same cycle
    assign stall_o = recover_i ||
                     (instr_valid_i && has_dest_o && fl_empty_i) ||
                     (instr_valid_i && is_branch && ckpt_full_i);

    assign rename_en_o = instr_valid_i && !stall_o;
    assign alloc_o     = rename_en_o && has_dest_o;
    assign take_ckpt_o = rename_en_o && is_branch;

endmodule

// ==== hdl/checkpoint_ctrl.sv ====
// Checkpoint label ring
// Hands out snapshot labels in order and retires them oldest first
// A recover cuts the ring back to the recovered label

`timescale 1ns/10ps
`include "rename_defs.svh"

module checkpoint_ctrl (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              take_i,
    input  logic              delete_i,        // Oldest branch resolved
    input  logic              recover_i,
    input  rename_pkg::ckpt_t recover_ckpt_i,
    output rename_pkg::ckpt_t new_ckpt_o,      // Label the next take fills
    output logic              ckpt_full_o
);
    localparam int CW = $clog2(`RN_NUM_CKPTS);

    rename_pkg::ckpt_t oldest_q;     // Oldest live label
    rename_pkg::ckpt_t newest_q;     // Most recent label taken
    logic [CW:0]       count_q;      // Live labels incl. the full case
    rename_pkg::ckpt_t rec_dist;     // Labels from oldest up to the recovered one

    assign rec_dist    = recover_ckpt_i - oldest_q;
    assign new_ckpt_o  = newest_q + 1'b1;
    assign ckpt_full_o = (count_q == (CW+1)'(`RN_NUM_CKPTS));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            oldest_q <= '0;
            newest_q <= '1;         // First take fills label 0
            count_q  <= '0;
        end else if (recover_i) begin
            // Drop every label younger than the recovered one
            newest_q <= recover_ckpt_i;
            count_q  <= {1'b0, rec_dist} + 1'b1;
        end else begin
            if (take_i)
                newest_q <= newest_q + 1'b1;
            if (delete_i)
                oldest_q <= oldest_q + 1'b1;
            count_q <= count_q + {{CW{1'b0}}, take_i} - {{CW{1'b0}}, delete_i};
        end
    end

    // Decode must hold back a branch once every label is live
    a_no_take_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        take_i |-> !ckpt_full_o);

    a_no_delete_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        delete_i |-> (count_q != '0));

    // Recovered label must lie between oldest and newest
    a_recover_live: assert property (@(posedge clk_i) disable iff (!rstn_i)
        recover_i |-> ({1'b0, rec_dist} < count_q));

endmodule

// ==== hdl/free_list.sv ====
// Physical register free list
// Circular FIFO of unmapped physical registers with one saved head per
// checkpoint so a mispredicted branch can rewind its allocations

`timescale 1ns/10ps
`include "rename_defs.svh"

module free_list (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              alloc_i,          // Pop the head register
    input  logic              free_i,           // Push a committed register
    input  logic              take_ckpt_i,
    input  logic              recover_i,
    input  rename_pkg::preg_t free_preg_i,
    input  rename_pkg::ckpt_t ckpt_i,
    input  rename_pkg::ckpt_t recover_ckpt_i,
    output rename_pkg::preg_t head_preg_o,
    output logic              empty_o
);
    localparam int PW = $clog2(`RN_FREE_DEPTH);

    rename_pkg::preg_t fl_mem [`RN_FREE_DEPTH];

    // Head carries a lap bit so a full lap since a snapshot is not lost
    logic [PW:0]   head_q;
    logic [PW-1:0] tail_q;
    logic [PW:0]   count_q;
    logic [PW:0]   head_nxt;
    logic [PW:0]   rewind;            // Allocations since the recovered snapshot
    logic [PW:0]   ckpt_head [`RN_NUM_CKPTS];

    assign head_nxt = head_q + {{PW{1'b0}}, alloc_i};
    assign rewind   = head_q - ckpt_head[recover_ckpt_i];

    assign head_preg_o = fl_mem[head_q[PW-1:0]];
    assign empty_o     = (count_q == '0);

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;                               // Full so tail meets head
            count_q <= (PW+1)'(`RN_FREE_DEPTH);
        end else begin
            tail_q <= tail_q + {{(PW-1){1'b0}}, free_i};  // Frees enter even on recover
            if (recover_i) begin
                // Squashed allocations go back in front of the head
                head_q  <= ckpt_head[recover_ckpt_i];
                count_q <= count_q + rewind + {{PW{1'b0}}, free_i};
            end else begin
                head_q  <= head_nxt;
                count_q <= count_q + {{PW{1'b0}}, free_i} - {{PW{1'b0}}, alloc_i};
            end
        end
    end

    // Register storage
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Registers above the architectural range start out free
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                fl_mem[i] <= rename_pkg::preg_t'(`RN_NUM_ARCH_REGS + i);
            end
        end else if (free_i) begin
            fl_mem[tail_q] <= free_preg_i;
        end
    end

    // Head as it stands after this cycle's rename
    always_ff @(posedge clk_i) begin
        if (take_ckpt_i && !recover_i)
            ckpt_head[ckpt_i] <= head_nxt;
    end

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        alloc_i |-> !empty_o);

    // A free while full means a register was returned twice
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (free_i && !alloc_i && !recover_i) |-> (count_q != (PW+1)'(`RN_FREE_DEPTH)));

endmodule

// ==== hdl/rename_table.sv ====
// Register map table
// Maps architectural sources and destinations to physical registers,
// keeps one map copy per checkpoint and registers the rename result

`timescale 1ns/10ps
`include "rename_defs.svh"

module rename_table (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              rename_en_i,       // Instruction accepted
    input  logic              has_dest_i,
    input  logic              take_ckpt_i,
    input  logic              recover_i,
    input  rename_pkg::areg_t rs1_i,
    input  rename_pkg::areg_t rs2_i,
    input  rename_pkg::areg_t rd_i,
    input  rename_pkg::preg_t new_preg_i,        // Free-list head
    input  rename_pkg::ckpt_t ckpt_i,
    input  rename_pkg::ckpt_t recover_ckpt_i,
    output logic              out_valid_o,
    output logic              out_has_dest_o,
    output logic              out_ckpt_valid_o,
    output rename_pkg::preg_t out_pdest_o,
    output rename_pkg::preg_t out_psrc1_o,
    output rename_pkg::preg_t out_psrc2_o,
    output rename_pkg::preg_t out_old_pdest_o,
    output rename_pkg::ckpt_t out_ckpt_o
);
    rename_pkg::map_t map_q;                      // Live speculative map
    rename_pkg::map_t map_nxt;                    // Map after this cycle's rename
    rename_pkg::map_t ckpt_map [`RN_NUM_CKPTS];   // Snapshot per label

    // Destination write applied on top of the current map
    always_comb begin
        map_nxt = map_q;
        if (rename_en_i && has_dest_i)
            map_nxt[rd_i] = new_preg_i;
    end

    // Live map
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RN_NUM_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::preg_t'(i);   // Identity map
            end
        end else if (recover_i) begin
            map_q <= ckpt_map[recover_ckpt_i];        // Single-cycle restore
        end else begin
            map_q <= map_nxt;
        end
    end

    // Snapshot holds the state after the branch itself
    always_ff @(posedge clk_i) begin
        if (take_ckpt_i && !recover_i)
            ckpt_map[ckpt_i] <= map_nxt;
    end

    // Result flags
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_o      <= 1'b0;
            out_has_dest_o   <= 1'b0;
            out_ckpt_valid_o <= 1'b0;
        end else begin
            out_valid_o      <= rename_en_i;          // One pulse per accepted instruction
            out_has_dest_o   <= rename_en_i && has_dest_i;
            out_ckpt_valid_o <= take_ckpt_i;
        end
    end

    // Result payload
    // Sources come from the old map so rs equal to rd sees the prior producer
    always_ff @(posedge clk_i) begin
        if (rename_en_i) begin
            out_psrc1_o     <= map_q[rs1_i];
            out_psrc2_o     <= map_q[rs2_i];
            out_old_pdest_o <= map_q[rd_i];           // Freed when this one commits
            out_pdest_o     <= has_dest_i ? new_preg_i : '0;
            out_ckpt_o      <= ckpt_i;
        end
    end

    // x0 must stay on p0 through renames and restores
    a_x0_p0: assert property (@(posedge clk_i) disable iff (!rstn_i)
        map_q[0] == '0);

    a_no_x0_dest: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rename_en_i && has_dest_i) |-> (rd_i != '0));

endmodule

// ==== hdl/rename_unit.sv ====
// Register rename stage
// One instruction per cycle through decode, free list, checkpoints and
// map table with a one-cycle registered result

`timescale 1ns/10ps

module rename_unit (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              instr_valid_i,
    input  isa_pkg::instr_u   instr_i,
    input  logic              free_valid_i,     // Commit returns a register
    input  rename_pkg::preg_t free_preg_i,
    input  logic              recover_i,        // Branch mispredicted
    input  rename_pkg::ckpt_t recover_ckpt_i,
    input  logic              delete_ckpt_i,    // Oldest branch resolved
    output logic              stall_o,
    output logic              out_valid_o,
    output rename_pkg::preg_t out_pdest_o,
    output rename_pkg::preg_t out_psrc1_o,
    output rename_pkg::preg_t out_psrc2_o,
    output rename_pkg::preg_t out_old_pdest_o,
    output logic              out_has_dest_o,
    output rename_pkg::ckpt_t out_ckpt_o,
    output logic              out_ckpt_valid_o
);
    rename_pkg::areg_t rs1;
    rename_pkg::areg_t rs2;
    rename_pkg::areg_t rd;
    logic              has_dest;
    logic              rename_en;
    logic              alloc;            // Pop strobe
    logic              take_ckpt;
    rename_pkg::preg_t head_preg;        // Next free register
    logic              fl_empty;
    rename_pkg::ckpt_t new_ckpt;         // Label for the next branch
    logic              ckpt_full;

    rename_decode u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .recover_i     (recover_i),
        .fl_empty_i    (fl_empty),
        .ckpt_full_i   (ckpt_full),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rd_o          (rd),
        .has_dest_o    (has_dest),
        .rename_en_o   (rename_en),
        .alloc_o       (alloc),
        .take_ckpt_o   (take_ckpt),
        .stall_o       (stall_o)
    );

    checkpoint_ctrl u_ckpt (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .take_i         (take_ckpt),
        .delete_i       (delete_ckpt_i),
        .recover_i      (recover_i),
        .recover_ckpt_i (recover_ckpt_i),
        .new_ckpt_o     (new_ckpt),
        .ckpt_full_o    (ckpt_full)
    );

    free_list u_free_list (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .alloc_i        (alloc),
        .free_i         (free_valid_i),
        .take_ckpt_i    (take_ckpt),
        .recover_i      (recover_i),
        .free_preg_i    (free_preg_i),
        .ckpt_i         (new_ckpt),
        .recover_ckpt_i (recover_ckpt_i),
        .head_preg_o    (head_preg),
        .empty_o        (fl_empty)
    );

    rename_table u_table (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .rename_en_i      (rename_en),
        .has_dest_i       (has_dest),
        .take_ckpt_i      (take_ckpt),
        .recover_i        (recover_i),
        .rs1_i            (rs1),
        .rs2_i            (rs2),
        .rd_i             (rd),
        .new_preg_i       (head_preg),
        .ckpt_i           (new_ckpt),
        .recover_ckpt_i   (recover_ckpt_i),
        .out_valid_o      (out_valid_o),
        .out_has_dest_o   (out_has_dest_o),
        .out_ckpt_valid_o (out_ckpt_valid_o),
        .out_pdest_o      (out_pdest_o),
        .out_psrc1_o      (out_psrc1_o),
        .out_psrc2_o      (out_psrc2_o),
        .out_old_pdest_o  (out_old_pdest_o),
        .out_ckpt_o       (out_ckpt_o)
    );

endmodule

// ==== tb/rename_ref.svh ====
// Rename reference model
// Map table, free FIFO, branch snapshots and live labels kept as testbench
// state and stepped once per clock with the inputs the DUT sees

`ifndef RENAME_REF_SVH
`define RENAME_REF_SVH

rename_pkg::preg_t ref_map [`RN_NUM_ARCH_REGS];
rename_pkg::preg_t ref_snap [`RN_NUM_CKPTS][`RN_NUM_ARCH_REGS];
int                snap_len [`RN_NUM_CKPTS];   // Allocation log length at each branch
int                br_seq [`RN_NUM_CKPTS];     // Program order of each branch
rename_pkg::preg_t ref_free [$];               // Free registers, head first
rename_pkg::preg_t alloc_log [$];              // Handed out since the oldest live branch
rename_pkg::ckpt_t ref_live [$];               // Oldest first
rename_pkg::ckpt_t next_label;
rename_pkg::preg_t pend_preg [$];              // Old mappings not yet committed
int                pend_seq [$];
int                seq_cnt;

// Expected DUT response for the cycle being driven
logic              exp_stall, exp_valid, exp_has_dest, exp_ckpt_valid;
rename_pkg::preg_t exp_pdest, exp_psrc1, exp_psrc2, exp_old;
rename_pkg::ckpt_t exp_ckpt;

function automatic void reset_model();
    ref_free.delete();
    alloc_log.delete();
    ref_live.delete();
    pend_preg.delete();
    pend_seq.delete();
    for (int i = 0; i < `RN_NUM_ARCH_REGS; i++)
        ref_map[i] = rename_pkg::preg_t'(i);        // Identity map
    for (int i = `RN_NUM_ARCH_REGS; i < `RN_NUM_PHYS_REGS; i++)
        ref_free.push_back(rename_pkg::preg_t'(i));
    next_label = '0;
    seq_cnt    = 0;
    exp_stall  = 1'b0;
    exp_valid  = 1'b0;
endfunction

// Committed register is safe to free once no live branch can squash it
function automatic logic commit_ok();
    if (pend_seq.size() == 0)
        return 1'b0;
    if (ref_live.size() == 0)
        return 1'b1;
    return pend_seq[0] < br_seq[ref_live[0]];
endfunction

function automatic void step_model(input logic valid, input isa_pkg::instr_u ins,
                                   input logic fv, input rename_pkg::preg_t fp,
                                   input logic rec, input rename_pkg::ckpt_t rl,
                                   input logic del);
    logic [6:0]        opc;
    logic              use1, use2, wr, br;
    rename_pkg::areg_t rs1, rs2, rd;
    opc  = ins[6:0];
    use1 = opc inside {isa_pkg::OP, isa_pkg::OP_IMM, isa_pkg::LOAD, isa_pkg::STORE,
                       isa_pkg::BRANCH};
    use2 = opc inside {isa_pkg::OP, isa_pkg::STORE, isa_pkg::BRANCH};
    wr   = opc inside {isa_pkg::OP, isa_pkg::OP_IMM, isa_pkg::LOAD, isa_pkg::LUI, isa_pkg::JAL};
    br   = (opc == isa_pkg::BRANCH);
    rs1  = use1 ? ins[19:15] : '0;
    rs2  = use2 ? ins[24:20] : '0;                  // I-type upper bits are immediate
    rd   = wr ? ins[11:7] : '0;
    exp_has_dest   = (rd != '0);
    exp_stall      = rec || (valid && exp_has_dest && (ref_free.size() == 0)) ||
                     (valid && br && (ref_live.size() == `RN_NUM_CKPTS));
    exp_valid      = valid && !exp_stall;
    exp_ckpt_valid = exp_valid && br;
    if (fv) begin
        ref_free.push_back(fp);                     // Frees enter even during recover
        void'(pend_preg.pop_front());
        void'(pend_seq.pop_front());
    end
    if (rec) begin
        for (int i = 0; i < `RN_NUM_ARCH_REGS; i++)
            ref_map[i] = ref_snap[rl][i];
        // Squashed allocations return to the head, oldest in front
        while (alloc_log.size() > snap_len[rl])
            ref_free.push_front(alloc_log.pop_back());
        while (ref_live[$] != rl)
            void'(ref_live.pop_back());
        while ((pend_seq.size() != 0) && (pend_seq[$] > br_seq[rl])) begin
            void'(pend_preg.pop_back());
            void'(pend_seq.pop_back());
        end
        next_label = rl + 1'b1;
    end else begin
        if (del)
            void'(ref_live.pop_front());
        if (exp_valid) begin
            exp_psrc1 = ref_map[rs1];               // Sources before the rd write
            exp_psrc2 = ref_map[rs2];
            exp_old   = ref_map[rd];
            exp_pdest = '0;
            if (exp_has_dest) begin
                exp_pdest   = ref_free.pop_front();
                ref_map[rd] = exp_pdest;
                alloc_log.push_back(exp_pdest);
                pend_preg.push_back(exp_old);
                pend_seq.push_back(seq_cnt);
            end
            if (br) begin
                if (ref_live.size() == 0)
                    alloc_log.delete();             // Nothing older can be rewound
                exp_ckpt = next_label;
                for (int i = 0; i < `RN_NUM_ARCH_REGS; i++)
                    ref_snap[next_label][i] = ref_map[i];
                snap_len[next_label] = alloc_log.size();
                br_seq[next_label]   = seq_cnt;
                ref_live.push_back(next_label);
                next_label = next_label + 1'b1;
            end
            seq_cnt++;
        end
    end
endfunction

`endif

// ==== tb/tb_rename_unit.sv ====
// Rename stage testbench
// Directed and random instruction streams checked against a reference model

`timescale 1ns/10ps
`include "rename_defs.svh"

module tb_rename_unit;
    logic              clk_i = 1'b0;
    logic              rstn_i;
    logic              instr_valid_i;
    isa_pkg::instr_u   instr_i;
    logic              free_valid_i;
    rename_pkg::preg_t free_preg_i;
    logic              recover_i;
    rename_pkg::ckpt_t recover_ckpt_i;
    logic              delete_ckpt_i;
    logic              stall_o, out_valid_o, out_has_dest_o, out_ckpt_valid_o;
    rename_pkg::preg_t out_pdest_o, out_psrc1_o, out_psrc2_o, out_old_pdest_o;
    rename_pkg::ckpt_t out_ckpt_o;

    logic [31:0]       rng_state;
    // Expectation delayed one cycle to line up with the registered outputs
    logic              prv_valid, prv_has_dest, prv_ckpt_valid;
    rename_pkg::preg_t prv_pdest, prv_psrc1, prv_psrc2, prv_old;
    rename_pkg::ckpt_t prv_ckpt;

    `include "rename_ref.svh"

    rename_unit u_dut (
        .clk_i (clk_i), .rstn_i (rstn_i), .instr_valid_i (instr_valid_i), .instr_i (instr_i),
        .free_valid_i (free_valid_i), .free_preg_i (free_preg_i), .recover_i (recover_i),
        .recover_ckpt_i (recover_ckpt_i), .delete_ckpt_i (delete_ckpt_i), .stall_o (stall_o),
        .out_valid_o (out_valid_o), .out_pdest_o (out_pdest_o), .out_psrc1_o (out_psrc1_o),
        .out_psrc2_o (out_psrc2_o), .out_old_pdest_o (out_old_pdest_o),
        .out_has_dest_o (out_has_dest_o), .out_ckpt_o (out_ckpt_o),
        .out_ckpt_valid_o (out_ckpt_valid_o)
    );

    always #5 clk_i = ~clk_i;       // 10 ns period

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_preg(input string name, input rename_pkg::preg_t act,
                              input rename_pkg::preg_t exp);
        if (act !== exp)
            fail_stop($sformatf("MISMATCH t=%0t %s expected p%0d actual p%0d",
                                $time, name, exp, act));
    endtask

    task automatic check_ckpt(input string name, input rename_pkg::ckpt_t act,
                              input rename_pkg::ckpt_t exp);
        if (act !== exp)
            fail_stop($sformatf("MISMATCH t=%0t %s expected %0d actual %0d",
                                $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
            fail_stop($sformatf("MISMATCH t=%0t %s expected %b actual %b",
                                $time, name, exp, act));
    endtask

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic isa_pkg::instr_u mk_r(input isa_pkg::opcode_e op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, op};
    endfunction

    function automatic isa_pkg::instr_u mk_i(input isa_pkg::opcode_e op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    // Random fields under one of the seven opcode classes
    function automatic isa_pkg::instr_u rand_instr();
        logic [31:0]       r;
        isa_pkg::opcode_e  op;
        r = xorshift();
        case (r[2:0])
            3'd1:    op = isa_pkg::OP_IMM;
            3'd2:    op = isa_pkg::LOAD;
            3'd3:    op = isa_pkg::STORE;
            3'd4:    op = isa_pkg::BRANCH;
            3'd5:    op = isa_pkg::LUI;
            3'd6:    op = isa_pkg::JAL;
            default: op = isa_pkg::OP;
        endcase
        return {r[31:7], op};
    endfunction

    // One cycle of stimulus, model step and the DUT's accept at the next edge
    task automatic drive_cycle(input logic valid, input isa_pkg::instr_u ins, input logic fv,
                               input logic rec, input rename_pkg::ckpt_t rl, input logic del,
                               output logic took);
        @(negedge clk_i);
        instr_valid_i  = valid;
        instr_i        = ins;
        free_valid_i   = fv;
        free_preg_i    = fv ? pend_preg[0] : '0;    // Oldest committed old mapping
        recover_i      = rec;
        recover_ckpt_i = rl;
        delete_ckpt_i  = del;
        step_model(valid, ins, fv, free_preg_i, rec, rl, del);
        @(posedge clk_i);
        took = valid && !stall_o;
    endtask

    // Hold one instruction until the stage takes it
    task automatic issue(input isa_pkg::instr_u ins);
        logic took;
        int   n;
        took = 1'b0;
        for (n = 0; (n < 40) && !took; n++)
            drive_cycle(1'b1, ins, 1'b0, 1'b0, '0, 1'b0, took);
        if (!took)
            fail_stop("Instruction was not accepted within 40 cycles");
    endtask

    task automatic refill(input int n);
        logic took;
        for (int k = 0; (k < n) && commit_ok(); k++)
            drive_cycle(1'b0, '0, 1'b1, 1'b0, '0, 1'b0, took);
    endtask

    task automatic run_random(input int n_instr);
        logic              took, fv, rec, del;
        logic [31:0]       r;
        rename_pkg::ckpt_t rl;
        isa_pkg::instr_u   ins;
        int                done;
        int                cycles;
        done = 0;
        ins  = rand_instr();
        for (cycles = 0; (cycles < 40 * n_instr) && (done < n_instr); cycles++) begin
            r   = xorshift();
            fv  = commit_ok() && r[0];
            rec = (ref_live.size() != 0) && (r[8:4] == 5'd0);
            rl  = (ref_live.size() != 0) ? ref_live[r[12:10] % ref_live.size()] : '0;
            del = !rec && (ref_live.size() != 0) && (r[15:13] == 3'd0);
            drive_cycle(r[3:1] != 3'd0, ins, fv, rec, rl, del, took);
            if (took) begin
                done++;
                ins = rand_instr();                 // New word only after accept
            end
        end
        if (done < n_instr)
            fail_stop("Random stream stopped making progress before its cycle limit");
    endtask

    // Stall checked in its own cycle and the renamed result one edge later
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            prv_valid = 1'b0;
        end else begin
            check_bit("stall_o", stall_o, exp_stall);
            check_bit("out_valid_o", out_valid_o, prv_valid);
            if (prv_valid) begin
                check_bit("out_has_dest_o", out_has_dest_o, prv_has_dest);
                check_preg("out_pdest_o", out_pdest_o, prv_pdest);
                check_preg("out_psrc1_o", out_psrc1_o, prv_psrc1);
                check_preg("out_psrc2_o", out_psrc2_o, prv_psrc2);
                if (prv_has_dest)
                    check_preg("out_old_pdest_o", out_old_pdest_o, prv_old);
                check_bit("out_ckpt_valid_o", out_ckpt_valid_o, prv_ckpt_valid);
                if (prv_ckpt_valid)
                    check_ckpt("out_ckpt_o", out_ckpt_o, prv_ckpt);
            end
            prv_valid      = exp_valid;
            prv_has_dest   = exp_has_dest;
            prv_ckpt_valid = exp_ckpt_valid;
            prv_pdest      = exp_pdest;
            prv_psrc1      = exp_psrc1;
            prv_psrc2      = exp_psrc2;
            prv_old        = exp_old;
            prv_ckpt       = exp_ckpt;
        end
    end

    initial begin
        logic            took;
        isa_pkg::instr_u ins;
        int              n;
        rng_state      = 32'h7b5;
        rstn_i         = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        free_valid_i   = 1'b0;
        free_preg_i    = '0;
        recover_i      = 1'b0;
        recover_ckpt_i = '0;
        delete_ckpt_i  = 1'b0;
        reset_model();
        repeat (5) @(negedge clk_i);
        rstn_i = 1'b1;

        // In-order allocation, source forwarding, x0 and store handling
        issue(mk_r(isa_pkg::OP, 5'd1, 5'd2, 5'd3));
        issue(mk_r(isa_pkg::OP, 5'd2, 5'd1, 5'd1));
        issue(mk_i(isa_pkg::OP_IMM, 5'd3, 5'd2, 12'hfff));  // rs2 bits hold imm
        issue(mk_r(isa_pkg::OP, 5'd0, 5'd3, 5'd1));         // rd x0
        issue(mk_r(isa_pkg::STORE, 5'd5, 5'd1, 5'd3));
        issue(mk_i(isa_pkg::LOAD, 5'd4, 5'd4, 12'h3a5));    // rs1 equal to rd
        issue(mk_r(isa_pkg::LUI, 5'd6, 5'd7, 5'd8));

        // Drain the free list so the next allocation must wait for a free
        for (n = 0; (n < 40) && (ref_free.size() != 0); n++)
            issue(mk_r(isa_pkg::OP, 5'((n % 31) + 1), 5'd1, 5'd2));
        if (ref_free.size() != 0)
            fail_stop("Free list did not drain after 40 allocations");
        ins = mk_r(isa_pkg::OP, 5'd9, 5'd9, 5'd10);
        drive_cycle(1'b1, ins, 1'b0, 1'b0, '0, 1'b0, took);
        if (took)
            fail_stop("Allocation was accepted with an empty free list");
        drive_cycle(1'b1, ins, 1'b1, 1'b0, '0, 1'b0, took);
        issue(ins);
        refill(12);

        // Four labels in order and a fifth branch held until a delete
        for (n = 0; n < 4; n++) begin
            issue(mk_r(isa_pkg::BRANCH, 5'd9, 5'(n + 1), 5'd2));
            issue(mk_r(isa_pkg::OP, 5'(n + 11), 5'(n + 1), 5'd3));
        end
        ins = mk_r(isa_pkg::BRANCH, 5'd0, 5'd11, 5'd12);
        drive_cycle(1'b1, ins, 1'b0, 1'b0, '0, 1'b0, took);
        if (took)
            fail_stop("Fifth branch was accepted with four live checkpoints");
        drive_cycle(1'b1, ins, 1'b0, 1'b0, '0, 1'b1, took);
        issue(ins);
        issue(mk_r(isa_pkg::OP, 5'd13, 5'd12, 5'd13));

        // Rewind to the second live label and rename past it again
        drive_cycle(1'b0, '0, 1'b0, 1'b1, 2'd2, 1'b0, took);
        issue(mk_r(isa_pkg::OP, 5'd14, 5'd13, 5'd12));
        issue(mk_i(isa_pkg::LOAD, 5'd13, 5'd14, 12'h010));
        issue(mk_r(isa_pkg::BRANCH, 5'd0, 5'd13, 5'd14));

        refill(20);
        run_random(2000);
        drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, 1'b0, took);
        drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, 1'b0, took);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
+incdir+tb
hdl/isa_pkg.sv
hdl/rename_pkg.sv
hdl/rename_decode.sv
hdl/checkpoint_ctrl.sv
hdl/free_list.sv
hdl/rename_table.sv
hdl/rename_unit.sv
tb/tb_rename_unit.sv
